//--- Makefile
SIM      := verilator
TOP      := tb_dcache_tag
FILELIST := sim.f
VFLAGS   := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address split is tag | index | offset
`define DC_ADDR_WIDTH	32
`define DC_OFFSET_WIDTH	6
`define DC_INDEX_WIDTH	6	// 64 sets
`define DC_TAG_WIDTH	20

`define DC_TID_WIDTH	8	// read transaction id

// in-flight request fifo
`define DC_FIFO_DEPTH	4
`define DC_FIFO_AFULL	3	// fill level where afull rises

`endif

//--- hdl/dcache_meta_pkg.sv
`include "dcache_cfg.svh"

package dcache_meta_pkg;

	typedef enum logic {
		S_IDLE = 1'b0,
		S_REQ  = 1'b1	// tag read pending
	} ext_state_e;

	typedef enum logic {
		LK_MISS = 1'b0,
		LK_HIT  = 1'b1
	} lookup_e;

	typedef logic [`DC_INDEX_WIDTH-1:0] set_idx_t;
	typedef logic [`DC_TAG_WIDTH-1:0]   tag_t;

endpackage

//--- hdl/dcache_req_pkg.sv
`include "dcache_cfg.svh"

package dcache_req_pkg;

	// op bit of a fifo entry and the kind of a result
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} acc_op_e;

	typedef logic [`DC_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DC_TID_WIDTH-1:0]  tid_t;	// 0 is kept for writes

endpackage

//--- hdl/dcache_tag_top.sv
`timescale 1ns/1ps

module dcache_tag_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    rd_valid_i,
	input  dcache_req_pkg::addr_t   rd_addr_i,
	output logic                    rd_ready_o,
	input  logic                    wr_valid_i,
	input  dcache_req_pkg::addr_t   wr_addr_i,
	output logic                    wr_ready_o,
	output logic                    res_valid_o,
	output logic                    res_hit_o,
	output dcache_req_pkg::acc_op_e res_op_o,
	output dcache_req_pkg::tid_t    res_tid_o,
	output dcache_req_pkg::addr_t   res_addr_o
);

	logic                      tag_rd_valid, tag_rd_ready;
	dcache_meta_pkg::set_idx_t tag_rd_index;
	logic                      tag_fifo_afull;
	logic                      fifo_wr_en, fifo_rd_en;
	dcache_req_pkg::acc_op_e   fifo_wr_op, fifo_rd_op;
	dcache_req_pkg::tid_t      fifo_wr_tid, fifo_rd_tid;
	dcache_req_pkg::addr_t     fifo_wr_addr, fifo_rd_addr;
	logic                      tag_resp_valid, tag_resp_valid_bit;
	dcache_meta_pkg::tag_t     tag_resp_tag;
	logic                      tag_wr_en;
	dcache_meta_pkg::set_idx_t tag_wr_index;
	dcache_meta_pkg::tag_t     tag_wr_tag;

	index_extractor u_extractor (
		.clk(clk), .rst_n(rst_n),
		.rd_valid_i(rd_valid_i), .rd_addr_i(rd_addr_i), .rd_ready_o(rd_ready_o),
		.wr_valid_i(wr_valid_i), .wr_addr_i(wr_addr_i), .wr_ready_o(wr_ready_o),
		.tag_rd_valid_o(tag_rd_valid), .tag_rd_index_o(tag_rd_index),
		.tag_rd_ready_i(tag_rd_ready), .fifo_afull_i(tag_fifo_afull),
		.fifo_wr_en_o(fifo_wr_en), .fifo_wr_op_o(fifo_wr_op),
		.fifo_wr_tid_o(fifo_wr_tid), .fifo_wr_addr_o(fifo_wr_addr)
	);

	tag_fifo u_fifo (
		.clk(clk), .rst_n(rst_n),
		.wr_en_i(fifo_wr_en), .wr_op_i(fifo_wr_op), .wr_tid_i(fifo_wr_tid),
		.wr_addr_i(fifo_wr_addr), .rd_en_i(fifo_rd_en), .rd_op_o(fifo_rd_op),
		.rd_tid_o(fifo_rd_tid), .rd_addr_o(fifo_rd_addr), .afull_o(tag_fifo_afull)
	);

	tag_array u_tags (
		.clk(clk), .rst_n(rst_n),
		.rd_valid_i(tag_rd_valid), .rd_index_i(tag_rd_index), .rd_ready_o(tag_rd_ready),
		.wr_en_i(tag_wr_en), .wr_index_i(tag_wr_index), .wr_tag_i(tag_wr_tag),
		.resp_valid_o(tag_resp_valid), .resp_valid_bit_o(tag_resp_valid_bit),
		.resp_tag_o(tag_resp_tag)
	);

	hit_checker u_checker (
		.clk(clk), .rst_n(rst_n),
		.resp_valid_i(tag_resp_valid), .resp_valid_bit_i(tag_resp_valid_bit),
		.resp_tag_i(tag_resp_tag), .fifo_rd_en_o(fifo_rd_en),
		.fifo_op_i(fifo_rd_op), .fifo_tid_i(fifo_rd_tid), .fifo_addr_i(fifo_rd_addr),
		.tag_wr_en_o(tag_wr_en), .tag_wr_index_o(tag_wr_index), .tag_wr_tag_o(tag_wr_tag),
		.res_valid_o(res_valid_o), .res_hit_o(res_hit_o), .res_op_o(res_op_o),
		.res_tid_o(res_tid_o), .res_addr_o(res_addr_o)
	);

endmodule

//--- hdl/hit_checker.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module hit_checker (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      resp_valid_i,
	input  logic                      resp_valid_bit_i,
	input  dcache_meta_pkg::tag_t     resp_tag_i,
	output logic                      fifo_rd_en_o,
	input  dcache_req_pkg::acc_op_e   fifo_op_i,
	input  dcache_req_pkg::tid_t      fifo_tid_i,
	input  dcache_req_pkg::addr_t     fifo_addr_i,
	output logic                      tag_wr_en_o,
	output dcache_meta_pkg::set_idx_t tag_wr_index_o,
	output dcache_meta_pkg::tag_t     tag_wr_tag_o,
	output logic                      res_valid_o,
	output logic                      res_hit_o,
	output dcache_req_pkg::acc_op_e   res_op_o,
	output dcache_req_pkg::tid_t      res_tid_o,
	output dcache_req_pkg::addr_t     res_addr_o
);

	dcache_meta_pkg::tag_t    addr_tag;
	dcache_meta_pkg::lookup_e lookup;
	dcache_meta_pkg::lookup_e res_lookup;

	// responses come back in request order, so the head is ours
	assign fifo_rd_en_o = resp_valid_i;
	assign addr_tag     = fifo_addr_i[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
	assign lookup       = (resp_valid_bit_i && (resp_tag_i == addr_tag)) ?
		dcache_meta_pkg::LK_HIT : dcache_meta_pkg::LK_MISS;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid_o <= 1'b0;
			tag_wr_en_o <= 1'b0;
		end else begin
			res_valid_o <= resp_valid_i;
			tag_wr_en_o <= resp_valid_i;	// every access allocates
		end
	end

	always_ff @(posedge clk) begin
		if (resp_valid_i) begin
			res_lookup     <= lookup;
			res_op_o       <= fifo_op_i;
			res_tid_o      <= fifo_tid_i;
			res_addr_o     <= fifo_addr_i;
			tag_wr_index_o <= fifo_addr_i[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
			tag_wr_tag_o   <= addr_tag;
		end
	end

	assign res_hit_o = (res_lookup == dcache_meta_pkg::LK_HIT);

endmodule

//--- hdl/index_extractor.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module index_extractor (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rd_valid_i,
	input  dcache_req_pkg::addr_t     rd_addr_i,
	output logic                      rd_ready_o,
	input  logic                      wr_valid_i,
	input  dcache_req_pkg::addr_t     wr_addr_i,
	output logic                      wr_ready_o,
	output logic                      tag_rd_valid_o,
	output dcache_meta_pkg::set_idx_t tag_rd_index_o,
	input  logic                      tag_rd_ready_i,
	input  logic                      fifo_afull_i,
	output logic                      fifo_wr_en_o,
	output dcache_req_pkg::acc_op_e   fifo_wr_op_o,
	output dcache_req_pkg::tid_t      fifo_wr_tid_o,
	output dcache_req_pkg::addr_t     fifo_wr_addr_o
);

	dcache_meta_pkg::ext_state_e state, state_n;
	logic                        wr_turn;	// write wins the next tie
	dcache_req_pkg::tid_t        tid;
	logic                        can_take;
	logic                        grant_rd;
	logic                        grant_wr;
	logic                        take;
	dcache_req_pkg::addr_t       grant_addr;

	assign can_take   = (state == dcache_meta_pkg::S_IDLE) && !fifo_afull_i;
	assign grant_rd   = can_take && rd_valid_i && (!wr_valid_i || !wr_turn);
	assign grant_wr   = can_take && wr_valid_i && (!rd_valid_i || wr_turn);
	assign take       = grant_rd || grant_wr;
	assign grant_addr = grant_rd ? rd_addr_i : wr_addr_i;

	assign rd_ready_o     = grant_rd;
	assign wr_ready_o     = grant_wr;
	assign tag_rd_valid_o = (state == dcache_meta_pkg::S_REQ);	// held until accepted

	always_comb begin
		state_n = state;
		case (state)
			dcache_meta_pkg::S_IDLE: begin
				if (take)
					state_n = dcache_meta_pkg::S_REQ;
			end
			dcache_meta_pkg::S_REQ: begin
				if (tag_rd_ready_i)
					state_n = dcache_meta_pkg::S_IDLE;
			end
			default: state_n = dcache_meta_pkg::S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= dcache_meta_pkg::S_IDLE;
			wr_turn      <= 1'b0;
			tid          <= dcache_req_pkg::tid_t'(1);
			fifo_wr_en_o <= 1'b0;
		end else begin
			state        <= state_n;
			fifo_wr_en_o <= take;	// single cycle push
			if (grant_rd)
				wr_turn <= 1'b1;
			else if (grant_wr)
				wr_turn <= 1'b0;
			// skip 0 on wrap since writes own it
			if (grant_rd)
				tid <= (&tid) ? dcache_req_pkg::tid_t'(1) : tid + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			tag_rd_index_o <= grant_addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
			fifo_wr_addr_o <= grant_addr;
			fifo_wr_op_o   <= grant_rd ? dcache_req_pkg::OP_READ : dcache_req_pkg::OP_WRITE;
			fifo_wr_tid_o  <= grant_rd ? tid : '0;
		end
	end

endmodule

//--- hdl/tag_array.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tag_array (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      rd_valid_i,
	input  dcache_meta_pkg::set_idx_t rd_index_i,
	output logic                      rd_ready_o,
	input  logic                      wr_en_i,
	input  dcache_meta_pkg::set_idx_t wr_index_i,
	input  dcache_meta_pkg::tag_t     wr_tag_i,
	output logic                      resp_valid_o,
	output logic                      resp_valid_bit_o,
	output dcache_meta_pkg::tag_t     resp_tag_o
);

	localparam int SETS = 1 << `DC_INDEX_WIDTH;

	dcache_meta_pkg::tag_t     tags [SETS];
	logic [SETS-1:0]           valid_bits;
	logic                      rd_fire;
	logic                      s1_valid, s2_valid;
	dcache_meta_pkg::set_idx_t s1_index, s2_index;
	logic                      s1_vbit, s2_vbit;
	dcache_meta_pkg::tag_t     s1_tag, s2_tag;
	logic                      s1_fwd, s2_fwd;

	assign rd_ready_o = !wr_en_i;	// single port where write wins
	assign rd_fire    = rd_valid_i && rd_ready_o;
	assign s1_fwd     = wr_en_i && (wr_index_i == s1_index);
	assign s2_fwd     = wr_en_i && (wr_index_i == s2_index);

	always_ff @(posedge clk) begin
		if (wr_en_i)
			tags[wr_index_i] <= wr_tag_i;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_bits <= '0;
			s1_valid   <= 1'b0;
			s2_valid   <= 1'b0;
		end else begin
			if (wr_en_i)
				valid_bits[wr_index_i] <= 1'b1;
			s1_valid <= rd_fire;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s1_index <= rd_index_i;
			s1_tag   <= tags[rd_index_i];
			s1_vbit  <= valid_bits[rd_index_i];
		end
		s2_index <= s1_index;
		s2_tag   <= s1_fwd ? wr_tag_i : s1_tag;	// write landed while in stage 1
		s2_vbit  <= s1_fwd | s1_vbit;
	end

	assign resp_valid_o     = s2_valid;
	assign resp_tag_o       = s2_fwd ? wr_tag_i : s2_tag;
	assign resp_valid_bit_o = s2_fwd | s2_vbit;

endmodule

//--- hdl/tag_fifo.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tag_fifo (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wr_en_i,
	input  dcache_req_pkg::acc_op_e wr_op_i,
	input  dcache_req_pkg::tid_t    wr_tid_i,
	input  dcache_req_pkg::addr_t   wr_addr_i,
	input  logic                    rd_en_i,
	output dcache_req_pkg::acc_op_e rd_op_o,
	output dcache_req_pkg::tid_t    rd_tid_o,
	output dcache_req_pkg::addr_t   rd_addr_o,
	output logic                    afull_o
);

	localparam int DEPTH   = `DC_FIFO_DEPTH;
	localparam int PTR_W   = $clog2(DEPTH);
	localparam int ENTRY_W = 1 + `DC_TID_WIDTH + `DC_ADDR_WIDTH;

	logic [ENTRY_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W:0]     count;
	logic [ENTRY_W-1:0] head;

	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_ptr] <= {wr_op_i, wr_tid_i, wr_addr_i};	// op | tid | addr
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en_i, rd_en_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// show-ahead head
	assign head      = mem[rd_ptr];
	assign rd_op_o   = dcache_req_pkg::acc_op_e'(head[ENTRY_W-1]);
	assign rd_tid_o  = head[`DC_ADDR_WIDTH +: `DC_TID_WIDTH];
	assign rd_addr_o = head[`DC_ADDR_WIDTH-1:0];
	assign afull_o   = (count >= `DC_FIFO_AFULL);

endmodule

//--- sim.f
+incdir+hdl
hdl/dcache_req_pkg.sv
hdl/dcache_meta_pkg.sv
hdl/index_extractor.sv
hdl/tag_fifo.sv
hdl/tag_array.sv
hdl/hit_checker.sv
hdl/dcache_tag_top.sv
test/dcache_tag_chk.sv
test/tb_dcache_tag.sv

//--- test/dcache_tag_chk.sv
`timescale 1ns/1ps

module dcache_tag_chk (
	input logic clk,
	input logic rst_n,
	input logic rd_ready_i,
	input logic wr_ready_i,
	input logic afull_i,
	input logic tag_rd_valid_i,
	input logic tag_rd_ready_i,
	input logic fifo_wr_en_i,
	input logic fifo_rd_en_i
);

	logic [2:0] occ;	// fifo fill level seen from outside

	always_ff @(posedge clk) begin
		if (!rst_n)
			occ <= '0;
		else
			occ <= occ + {2'b0, fifo_wr_en_i} - {2'b0, fifo_rd_en_i};
	end

	a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_ready_i && wr_ready_i)) else $error("read and write ready high together");
	a_afull_stop: assert property (@(posedge clk) disable iff (!rst_n)
		afull_i |-> !(rd_ready_i || wr_ready_i)) else $error("ready pulse while almost full");
	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		tag_rd_valid_i && !tag_rd_ready_i |=> tag_rd_valid_i) else $error("tag read dropped");
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_rd_en_i |-> occ != 0) else $error("pop from empty tag fifo");

endmodule

bind dcache_tag_top dcache_tag_chk u_chk (
	.clk(clk), .rst_n(rst_n), .rd_ready_i(rd_ready_o), .wr_ready_i(wr_ready_o),
	.afull_i(tag_fifo_afull), .tag_rd_valid_i(tag_rd_valid), .tag_rd_ready_i(tag_rd_ready),
	.fifo_wr_en_i(fifo_wr_en), .fifo_rd_en_i(fifo_rd_en)
);

//--- test/tb_dcache_tag.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache_tag;

	localparam int TIMEOUT = 50;	// cycles per wait
	localparam int SETS    = 1 << `DC_INDEX_WIDTH;

	// op, expected hit, address
	localparam logic [33:0] STIM [8] = '{
		{1'b0, 1'b0, 32'h12345140},	// cold read
		{1'b0, 1'b1, 32'h12345140},	// same line again with tid 2
		{1'b1, 1'b0, 32'habcde240},	// write allocates
		{1'b0, 1'b1, 32'habcde250},
		{1'b0, 1'b0, 32'h00111500},	// set 20 where A and B evict each other
		{1'b0, 1'b0, 32'h00222500},
		{1'b0, 1'b0, 32'h00111500},
		{1'b1, 1'b1, 32'h00111500}
	};
	localparam dcache_meta_pkg::set_idx_t RAND_SETS [3] = '{6'd3, 6'd17, 6'd42};
	localparam dcache_meta_pkg::tag_t RAND_TAGS [4] = '{20'h00001, 20'h0beef, 20'h7a5a5, 20'hfffff};

	logic clk = 1'b0;
	logic rst_n, rd_valid_i, wr_valid_i, rd_ready_o, wr_ready_o, res_valid_o, res_hit_o;
	dcache_req_pkg::addr_t rd_addr_i, wr_addr_i, res_addr_o;
	dcache_req_pkg::acc_op_e res_op_o;
	dcache_req_pkg::tid_t res_tid_o, next_tid;
	int errors = 0;
	int results = 0;
	int seed = 23;
	int rnd;
	logic ref_vld [SETS];
	dcache_meta_pkg::tag_t ref_tag [SETS];
	logic exp_op_q [$], exp_hit_q [$], grant_log [$];
	dcache_req_pkg::tid_t exp_tid_q [$];
	dcache_req_pkg::addr_t exp_addr_q [$];

	dcache_tag_top dut_i (.*);

	always #50 clk = ~clk;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// reference tag model where every access allocates its line
	task automatic record(input logic op, input dcache_req_pkg::addr_t addr, input int tbl_hit);
		dcache_meta_pkg::set_idx_t idx;
		dcache_meta_pkg::tag_t tag;
		logic hit;
		idx = addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
		tag = addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
		hit = ref_vld[idx] && (ref_tag[idx] == tag);
		ref_vld[idx] = 1'b1;
		ref_tag[idx] = tag;
		exp_hit_q.push_back(tbl_hit >= 0 ? tbl_hit[0] : hit);
		exp_op_q.push_back(op);
		exp_tid_q.push_back(op ? 8'h00 : next_tid);
		exp_addr_q.push_back(addr);
		grant_log.push_back(op);
		if (!op)
			next_tid = (next_tid == 8'hff) ? 8'h01 : next_tid + 8'h01;
	endtask

	task automatic issue(input logic op, input dcache_req_pkg::addr_t addr, input int tbl_hit);
		int waited;
		logic got;
		waited = 0;
		got = 1'b0;
		if (op) begin
			wr_valid_i = 1'b1;
			wr_addr_i  = addr;
		end else begin
			rd_valid_i = 1'b1;
			rd_addr_i  = addr;
		end
		while (!got && waited < TIMEOUT) begin
			@(negedge clk);
			got = op ? wr_ready_o : rd_ready_o;	// settled mid cycle
			@(posedge clk);
			#1;
			waited++;
		end
		if (op)
			wr_valid_i = 1'b0;
		else
			rd_valid_i = 1'b0;
		if (got)
			record(op, addr, tbl_hit);
		else begin
			$display("request for address %h (op %0d) was never accepted", addr, op);
			errors++;
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_addr_q.size() != 0 && waited < TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (exp_addr_q.size() != 0) begin
			$display("%0d requests got no result in time", exp_addr_q.size());
			errors++;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_tid = 8'h01;
		grant_log.delete();
		for (int s = 0; s < SETS; s++)
			ref_vld[s] = 1'b0;
	endtask

	always @(negedge clk) begin
		if (rst_n && res_valid_o) begin
			results++;
			if (exp_addr_q.size() == 0) begin
				$display("result for address %h arrived with nothing pending", res_addr_o);
				errors++;
			end else begin
				compare("res_op_o", 32'(res_op_o), 32'(exp_op_q.pop_front()));
				compare("res_hit_o", 32'(res_hit_o), 32'(exp_hit_q.pop_front()));
				compare("res_tid_o", 32'(res_tid_o), 32'(exp_tid_q.pop_front()));
				compare("res_addr_o", res_addr_o, exp_addr_q.pop_front());
			end
		end
	end

	initial begin
		rd_valid_i = 1'b0;
		wr_valid_i = 1'b0;
		rd_addr_i  = '0;
		wr_addr_i  = '0;
		apply_reset();
		for (int i = 0; i < 8; i++)
			issue(STIM[i][33], STIM[i][31:0], int'(STIM[i][32]));
		drain();
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			issue(rnd[0], {RAND_TAGS[rnd[5:4]], RAND_SETS[int'(rnd[9:8]) % 3], rnd[15:10]}, -1);
			// idle gaps move a tag read onto a tag write cycle
			repeat (rnd[17:16]) begin
				@(posedge clk);
				#1;
			end
		end
		drain();
		// both valids held so grants alternate from read
		apply_reset();
		fork
			for (int i = 0; i < 3; i++)
				issue(1'b0, {20'(1 + i % 2), 6'd30, 6'h00}, -1);
			for (int j = 0; j < 3; j++)
				issue(1'b1, {20'(1 + j), 6'd30, 6'h08}, -1);
		join
		drain();
		if (grant_log.size() != 6) begin
			$display("tie phase saw %0d grants instead of 6", grant_log.size());
			errors++;
		end
		foreach (grant_log[i])
			compare("wr_ready_o", 32'(grant_log[i]), 32'(i % 2));
		$display("results %0d, errors %0d", results, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
